// ==== a2_card.f ====
a2bus_pkg.sv
a2status_pkg.sv
signal_denoise.sv
bus_timing.sv
card_data_select.sv
scanline_dimmer.sv
status_leds.sv
a2_card_top.sv
tb_a2_card_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message in the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log \
    && verilator --binary --timing --assert --top-module tb_a2_card_top \
        -f a2_card.f -o sim_a2_card > build.log 2>&1 \
    && ./obj_dir/sim_a2_card > sim.log 2>&1 \
    && grep -q "All tests passed" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// ==== tb_a2_card_top.sv ====
// Testbench for the Apple II card bus front end
// Directed tests for bus clock conditioning, reset combining, card data
// arbitration, scanline dimming and the status LEDs

module tb_a2_card_top
    import a2bus_pkg::*;
    import a2status_pkg::*;
();

    // Generous bound over the length of all tests
    localparam int timeout_cycles = 2000;

    logic                      clk_logic_w;
    logic                      reset_i;
    logic                      a2_phi1_i;
    logic                      a2_7m_i;
    logic                      a2_reset_n_i;
    bus_byte_t                 a2_data_i;
    logic      [num_cards-1:0] card_rd_i;
    bus_byte_t [num_cards-1:0] card_data_i;
    logic      [num_irq-1:0]   card_irq_n_i;
    logic      [3:0]           dip_switches_n_i;
    logic      [9:0]           screen_y_i;
    logic      [rgb_w-1:0]     pixel_r_i;
    logic      [rgb_w-1:0]     pixel_g_i;
    logic      [rgb_w-1:0]     pixel_b_i;
    logic                      button_n_i;
    logic                      text_mode_i;
    logic                      shrg_mode_i;
    logic                      hires_mode_i;
    logic                      ramwrt_i;
    logic                      store80_i;
    logic                      vdp_unlocked_i;
    logic      [gmode_w-1:0]   vdp_gmode_i;
    logic                      phi0_o;
    logic                      phi1_o;
    logic                      clk_2m_posedge_o;
    logic                      clk_14m_posedge_o;
    logic                      system_reset_o;
    bus_byte_t                 data_out_o;
    logic                      data_out_en_o;
    logic                      irq_n_o;
    logic      [rgb_w-1:0]     dim_r_o;
    logic      [rgb_w-1:0]     dim_g_o;
    logic      [rgb_w-1:0]     dim_b_o;
    led_word_t                 led_o;

    int          check_count;
    int          mismatch_count;
    int          other_error_count;
    int          cycle_count;

    a2_card_top u_a2_card_top (.*);

    initial begin
        clk_logic_w = 1'b0;
        forever #50 clk_logic_w = ~clk_logic_w;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        assert (actual === expected) else begin
            mismatch_count++;
            $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_true(input bit ok, input string what);
        check_count++;
        assert (ok) else begin
            other_error_count++;
            $display("ERROR time=%0t %s", $time, what);
        end
    endtask

    // Moves phi1 or 7M to a new level and follows the strobe for 5 cycles
    task automatic drive_clock_edge(input bit use_phi1, input bit new_level);
        logic  strobe;
        logic  phi1_exp;
        string strobe_name;
        if (use_phi1) begin
            a2_phi1_i   = new_level;
            strobe_name = "clk_2m_posedge_o";
        end else begin
            a2_7m_i     = new_level;
            strobe_name = "clk_14m_posedge_o";
        end
        // First sampled at the next rising edge, output moves three edges later
        for (int cycle = 1; cycle <= 5; cycle++) begin
            @(negedge clk_logic_w);
            strobe   = use_phi1 ? clk_2m_posedge_o : clk_14m_posedge_o;
            phi1_exp = (cycle >= 4) ? new_level : !new_level;
            check_value(strobe_name, 32'(strobe), 32'(cycle == 4));
            if (use_phi1) begin
                check_value("phi1_o", 32'(phi1_o), 32'(phi1_exp));
                check_value("phi0_o", 32'(phi0_o), 32'(!phi1_exp));
            end
        end
    endtask

    task automatic test_reset_state();
        check_value("phi1_o", 32'(phi1_o), 32'd0);
        check_value("phi0_o", 32'(phi0_o), 32'd1);
        check_value("data_out_en_o", 32'(data_out_en_o), 32'd0);
        check_value("irq_n_o", 32'(irq_n_o), 32'd1);
        check_value("dim_r_o", 32'(dim_r_o), 32'd0);
        check_value("dim_g_o", 32'(dim_g_o), 32'd0);
        check_value("dim_b_o", 32'(dim_b_o), 32'd0);
        check_value("led_o", 32'(led_o.bits), 32'h1f);
    endtask

    task automatic test_phi1_conditioning();
        drive_clock_edge(1'b1, 1'b1);
        // One-cycle low glitch must be filtered out
        a2_phi1_i = 1'b0;
        @(negedge clk_logic_w);
        a2_phi1_i = 1'b1;
        repeat (5) begin
            @(negedge clk_logic_w);
            check_value("phi1_o", 32'(phi1_o), 32'd1);
            check_value("clk_2m_posedge_o", 32'(clk_2m_posedge_o), 32'd0);
        end
        drive_clock_edge(1'b1, 1'b0);
    endtask

    task automatic test_7m_and_reset();
        int wait_cycles;
        drive_clock_edge(1'b0, 1'b1);
        drive_clock_edge(1'b0, 1'b0);
        check_value("system_reset_o", 32'(system_reset_o), 32'd0);
        a2_reset_n_i = 1'b0;
        wait_cycles  = 0;
        while (!system_reset_o && wait_cycles < 6) begin
            @(negedge clk_logic_w);
            wait_cycles++;
        end
        check_true(system_reset_o,
                   "system_reset_o did not rise within 6 cycles of a2_reset_n_i low");
        a2_reset_n_i = 1'b1;
        wait_cycles  = 0;
        while (system_reset_o && wait_cycles < 6) begin
            @(negedge clk_logic_w);
            wait_cycles++;
        end
        check_true(!system_reset_o, "system_reset_o stayed high after a2_reset_n_i was released");
    endtask

    task automatic test_data_arbitration();
        bus_byte_t exp_data;
        logic      found;
        logic      exp_en;
        logic      exp_irq_n;
        repeat (40) begin
            card_rd_i = ($urandom_range(0, 3) == 0) ? '0 : num_cards'($urandom);
            for (int i = 0; i < num_cards; i++) begin
                card_data_i[i] = bus_data_w'($urandom);
            end
            a2_data_i    = bus_data_w'($urandom);
            card_irq_n_i = ($urandom_range(0, 1) == 0) ? '1 : num_irq'($urandom);
            // Lowest card index that reads owns the bus
            exp_data = a2_data_i;
            found    = 1'b0;
            for (int i = 0; i < num_cards; i++) begin
                if (card_rd_i[i] && !found) begin
                    exp_data = card_data_i[i];
                    found    = 1'b1;
                end
            end
            exp_en    = |card_rd_i;
            exp_irq_n = &card_irq_n_i;
            @(negedge clk_logic_w);
            check_value("data_out_o", 32'(data_out_o), 32'(exp_data));
            check_value("data_out_en_o", 32'(data_out_en_o), 32'(exp_en));
            check_value("irq_n_o", 32'(irq_n_o), 32'(exp_irq_n));
        end
        card_rd_i = '0;
    endtask

    task automatic test_scanline_dimming();
        logic             dim_exp;
        logic [rgb_w-1:0] exp_r;
        logic [rgb_w-1:0] exp_g;
        logic [rgb_w-1:0] exp_b;
        // Mode bit 0 is the switch level, bit 1 the line parity
        for (int mode = 0; mode < 4; mode++) begin
            repeat (6) begin
                dip_switches_n_i                    = 4'($urandom);
                dip_switches_n_i[dip_scanlines_bit] = mode[0];
                screen_y_i                          = 10'($urandom);
                screen_y_i[0]                       = mode[1];
                pixel_r_i = rgb_w'($urandom);
                pixel_g_i = rgb_w'($urandom);
                pixel_b_i = rgb_w'($urandom);
                dim_exp = !dip_switches_n_i[dip_scanlines_bit] && screen_y_i[0];
                exp_r   = dim_exp ? (pixel_r_i >> 1) : pixel_r_i;
                exp_g   = dim_exp ? (pixel_g_i >> 1) : pixel_g_i;
                exp_b   = dim_exp ? (pixel_b_i >> 1) : pixel_b_i;
                @(negedge clk_logic_w);
                check_value("dim_r_o", 32'(dim_r_o), 32'(exp_r));
                check_value("dim_g_o", 32'(dim_g_o), 32'(exp_g));
                check_value("dim_b_o", 32'(dim_b_o), 32'(exp_b));
            end
        end
    endtask

    task automatic test_status_leds();
        logic [led_w-1:0] exp_leds;
        for (int view = 0; view < 2; view++) begin
            repeat (8) begin
                button_n_i = view[0];
                {text_mode_i, shrg_mode_i, hires_mode_i, ramwrt_i, store80_i} = 5'($urandom);
                vdp_unlocked_i = 1'($urandom);
                vdp_gmode_i    = gmode_w'($urandom);
                if (!button_n_i) begin
                    exp_leds = ~{text_mode_i, shrg_mode_i, hires_mode_i, ramwrt_i, store80_i};
                end else begin
                    exp_leds = ~{vdp_unlocked_i, vdp_gmode_i};
                end
                @(negedge clk_logic_w);
                check_value("led_o", 32'(led_o.bits), 32'(exp_leds));
            end
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk_logic_w);
            cycle_count++;
        end
        $display("ERROR run stopped after %0d cycles without finishing", cycle_count);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(99));
        check_count       = 0;
        mismatch_count    = 0;
        other_error_count = 0;
        reset_i           = 1'b1;
        a2_phi1_i         = 1'b0;
        a2_7m_i           = 1'b0;
        a2_reset_n_i      = 1'b1;
        a2_data_i         = '0;
        card_rd_i         = '0;
        card_data_i       = '0;
        card_irq_n_i      = '1;
        dip_switches_n_i  = 4'hf;
        screen_y_i        = '0;
        pixel_r_i         = '0;
        pixel_g_i         = '0;
        pixel_b_i         = '0;
        button_n_i        = 1'b1;
        text_mode_i       = 1'b0;
        shrg_mode_i       = 1'b0;
        hires_mode_i      = 1'b0;
        ramwrt_i          = 1'b0;
        store80_i         = 1'b0;
        vdp_unlocked_i    = 1'b0;
        vdp_gmode_i       = '0;
        repeat (3) @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        test_reset_state();
        reset_i = 1'b0;
        @(negedge clk_logic_w);
        test_phi1_conditioning();
        test_7m_and_reset();
        test_data_arbitration();
        test_scanline_dimming();
        test_status_leds();
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, other_error_count);
        if (mismatch_count == 0 && other_error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== a2_card_top.sv ====
// Apple II card bus front end
// Bus clock conditioning, reset combining, card read data arbitration,
// scanline dimming and the status LEDs, all on the logic clock

module a2_card_top
    import a2bus_pkg::*;
    import a2status_pkg::*;
#(
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,
    parameter bit IRQ_OUT_ENABLE      = 1'b1,
    parameter bit SCANLINES_ENABLE    = 1'b0
) (
    input  logic                      clk_logic_w,
    input  logic                      reset_i,
    input  logic                      a2_phi1_i,
    input  logic                      a2_7m_i,
    input  logic                      a2_reset_n_i,
    input  bus_byte_t                 a2_data_i,
    input  logic      [num_cards-1:0] card_rd_i,
    input  bus_byte_t [num_cards-1:0] card_data_i,
    input  logic      [num_irq-1:0]   card_irq_n_i,
    input  logic      [3:0]           dip_switches_n_i,
    input  logic      [9:0]           screen_y_i,
    input  logic      [rgb_w-1:0]     pixel_r_i,
    input  logic      [rgb_w-1:0]     pixel_g_i,
    input  logic      [rgb_w-1:0]     pixel_b_i,
    input  logic                      button_n_i,
    input  logic                      text_mode_i,
    input  logic                      shrg_mode_i,
    input  logic                      hires_mode_i,
    input  logic                      ramwrt_i,
    input  logic                      store80_i,
    input  logic                      vdp_unlocked_i,
    input  logic      [gmode_w-1:0]   vdp_gmode_i,
    output logic                      phi0_o,
    output logic                      phi1_o,
    output logic                      clk_2m_posedge_o,
    output logic                      clk_14m_posedge_o,
    output logic                      system_reset_o,
    output bus_byte_t                 data_out_o,
    output logic                      data_out_en_o,
    output logic                      irq_n_o,
    output logic      [rgb_w-1:0]     dim_r_o,
    output logic      [rgb_w-1:0]     dim_g_o,
    output logic      [rgb_w-1:0]     dim_b_o,
    output led_word_t                 led_o
);

    bus_timing u_bus_timing (
        .clk_logic_w       (clk_logic_w),
        .reset_i           (reset_i),
        .a2_phi1_i         (a2_phi1_i),
        .a2_7m_i           (a2_7m_i),
        .a2_reset_n_i      (a2_reset_n_i),
        .phi0_o            (phi0_o),
        .phi1_o            (phi1_o),
        .clk_2m_posedge_o  (clk_2m_posedge_o),
        .clk_14m_posedge_o (clk_14m_posedge_o),
        .system_reset_o    (system_reset_o)
    );

    card_data_select #(
        .BUS_DATA_OUT_ENABLE (BUS_DATA_OUT_ENABLE),
        .IRQ_OUT_ENABLE      (IRQ_OUT_ENABLE)
    ) u_card_data_select (
        .clk_logic_w   (clk_logic_w),
        .reset_i       (reset_i),
        .a2_data_i     (a2_data_i),
        .card_rd_i     (card_rd_i),
        .card_data_i   (card_data_i),
        .card_irq_n_i  (card_irq_n_i),
        .data_out_o    (data_out_o),
        .data_out_en_o (data_out_en_o),
        .irq_n_o       (irq_n_o)
    );

    scanline_dimmer #(
        .SCANLINES_ENABLE (SCANLINES_ENABLE)
    ) u_scanline_dimmer (
        .clk_logic_w      (clk_logic_w),
        .reset_i          (reset_i),
        .dip_switches_n_i (dip_switches_n_i),
        .screen_y_i       (screen_y_i),
        .pixel_r_i        (pixel_r_i),
        .pixel_g_i        (pixel_g_i),
        .pixel_b_i        (pixel_b_i),
        .dim_r_o          (dim_r_o),
        .dim_g_o          (dim_g_o),
        .dim_b_o          (dim_b_o)
    );

    status_leds u_status_leds (
        .clk_logic_w    (clk_logic_w),
        .reset_i        (reset_i),
        .button_n_i     (button_n_i),
        .text_mode_i    (text_mode_i),
        .shrg_mode_i    (shrg_mode_i),
        .hires_mode_i   (hires_mode_i),
        .ramwrt_i       (ramwrt_i),
        .store80_i      (store80_i),
        .vdp_unlocked_i (vdp_unlocked_i),
        .vdp_gmode_i    (vdp_gmode_i),
        .led_o          (led_o)
    );

endmodule

// ==== status_leds.sv ====
// Status LED register
// Button held shows the Apple video mode flags, released shows the
// VDP unlock state and graphics mode. LEDs are lit when low.

module status_leds
    import a2status_pkg::*;
(
    input  logic               clk_logic_w,
    input  logic               reset_i,
    input  logic               button_n_i,
    input  logic               text_mode_i,
    input  logic               shrg_mode_i,
    input  logic               hires_mode_i,
    input  logic               ramwrt_i,
    input  logic               store80_i,
    input  logic               vdp_unlocked_i,
    input  logic [gmode_w-1:0] vdp_gmode_i,
    output led_word_t          led_o
);

    led_word_t view_w;

    always_comb begin
        view_w.bits = '1;
        if (!button_n_i) begin
            view_w.mode.text_n    = ~text_mode_i;
            view_w.mode.shrg_n    = ~shrg_mode_i;
            view_w.mode.hires_n   = ~hires_mode_i;
            view_w.mode.ramwrt_n  = ~ramwrt_i;
            view_w.mode.store80_n = ~store80_i;
        end else begin
            view_w.vdp.unlocked_n = ~vdp_unlocked_i;
            view_w.vdp.gmode_n    = ~vdp_gmode_i;
        end
    end

    // All off out of reset
    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            led_o.bits <= '1;
        end else begin
            led_o <= view_w;
        end
    end

endmodule

// ==== scanline_dimmer.sv ====
// Scanline dimmer
// Halves every colour channel on odd lines when scanlines are on,
// either by the build setting or by the DIP switch

module scanline_dimmer
    import a2bus_pkg::*;
#(
    parameter bit SCANLINES_ENABLE = 1'b0
) (
    input  logic             clk_logic_w,
    input  logic             reset_i,
    input  logic [3:0]       dip_switches_n_i,
    input  logic [9:0]       screen_y_i,
    input  logic [rgb_w-1:0] pixel_r_i,
    input  logic [rgb_w-1:0] pixel_g_i,
    input  logic [rgb_w-1:0] pixel_b_i,
    output logic [rgb_w-1:0] dim_r_o,
    output logic [rgb_w-1:0] dim_g_o,
    output logic [rgb_w-1:0] dim_b_o
);

    logic scanlines_on_w;
    logic dim_active_w;

    assign scanlines_on_w = SCANLINES_ENABLE | ~dip_switches_n_i[dip_scanlines_bit];
    // Odd lines only
    assign dim_active_w   = scanlines_on_w & screen_y_i[0];

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            dim_r_o <= '0;
            dim_g_o <= '0;
            dim_b_o <= '0;
        end else begin
            dim_r_o <= dim_active_w ? (pixel_r_i >> 1) : pixel_r_i;
            dim_g_o <= dim_active_w ? (pixel_g_i >> 1) : pixel_g_i;
            dim_b_o <= dim_active_w ? (pixel_b_i >> 1) : pixel_b_i;
        end
    end

endmodule

// ==== card_data_select.sv ====
// Card read data arbiter
// Picks the bus byte from the highest priority card that is reading,
// falls back to the latched bus byte, and merges the card interrupts.
// All outputs are registered, one cycle after the inputs.

module card_data_select
    import a2bus_pkg::*;
#(
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,
    parameter bit IRQ_OUT_ENABLE      = 1'b1
) (
    input  logic                      clk_logic_w,
    input  logic                      reset_i,
    input  bus_byte_t                 a2_data_i,
    input  logic      [num_cards-1:0] card_rd_i,
    input  bus_byte_t [num_cards-1:0] card_data_i,
    input  logic      [num_irq-1:0]   card_irq_n_i,
    output bus_byte_t                 data_out_o,
    output logic                      data_out_en_o,
    output logic                      irq_n_o
);

    bus_byte_t data_sel_w;
    logic      data_en_w;
    logic      irq_n_w;

    // Fixed priority, serial first
    always_comb begin
        if (card_rd_i[src_serial]) begin
            data_sel_w = card_data_i[src_serial];
        end else if (card_rd_i[src_sprite]) begin
            data_sel_w = card_data_i[src_sprite];
        end else if (card_rd_i[src_mockingboard]) begin
            data_sel_w = card_data_i[src_mockingboard];
        end else if (card_rd_i[src_disk]) begin
            data_sel_w = card_data_i[src_disk];
        end else if (card_rd_i[src_cardrom]) begin
            data_sel_w = card_data_i[src_cardrom];
        end else begin
            data_sel_w = a2_data_i;
        end
    end

    assign data_en_w = BUS_DATA_OUT_ENABLE & (|card_rd_i);
    assign irq_n_w   = IRQ_OUT_ENABLE ? (&card_irq_n_i) : 1'b1;

    always_ff @(posedge clk_logic_w) begin
        data_out_o <= data_sel_w;
    end

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            data_out_en_o <= 1'b0;
            irq_n_o       <= 1'b1;
        end else begin
            data_out_en_o <= data_en_w;
            irq_n_o       <= irq_n_w;
        end
    end

    a_en_needs_read: assert property (
        @(posedge clk_logic_w) disable iff (reset_i)
        data_out_en_o |-> $past(|card_rd_i)
    ) else $error("card_data_select: bus driven with no card reading");

endmodule

// ==== bus_timing.sv ====
// Apple II bus timing
// Cleans up phi1 and 7M, derives phi0 and the 2M and 14M edge strobes,
// and combines the local reset with the synchronized bus reset

module bus_timing (
    input  logic clk_logic_w,
    input  logic reset_i,
    input  logic a2_phi1_i,
    input  logic a2_7m_i,
    input  logic a2_reset_n_i,
    output logic phi0_o,
    output logic phi1_o,
    output logic clk_2m_posedge_o,
    output logic clk_14m_posedge_o,
    output logic system_reset_o
);

    logic       phi1_rise_w;
    logic       phi1_fall_w;
    logic       clk_7m_rise_w;
    logic       clk_7m_fall_w;
    logic [1:0] a2_reset_sync_q;
    logic       system_reset_q;

    signal_denoise u_phi1_denoise (
        .clk_logic_w (clk_logic_w),
        .reset_i     (reset_i),
        .sig_i       (a2_phi1_i),
        .level_o     (phi1_o),
        .rise_o      (phi1_rise_w),
        .fall_o      (phi1_fall_w)
    );

    // Only the edges of 7M are needed
    signal_denoise u_7m_denoise (
        .clk_logic_w (clk_logic_w),
        .reset_i     (reset_i),
        .sig_i       (a2_7m_i),
        .level_o     (),
        .rise_o      (clk_7m_rise_w),
        .fall_o      (clk_7m_fall_w)
    );

    assign phi0_o            = ~phi1_o;
    assign clk_2m_posedge_o  = phi1_rise_w | phi1_fall_w;
    assign clk_14m_posedge_o = clk_7m_rise_w | clk_7m_fall_w;

    // Bus reset synchronizer, released state is high
    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            a2_reset_sync_q <= 2'b11;
            system_reset_q  <= 1'b1;
        end else begin
            a2_reset_sync_q <= {a2_reset_sync_q[0], a2_reset_n_i};
            system_reset_q  <= ~a2_reset_sync_q[1];
        end
    end

    assign system_reset_o = system_reset_q;

    a_2m_on_phi1_edge: assert property (
        @(posedge clk_logic_w) disable iff (reset_i)
        clk_2m_posedge_o |-> (phi1_o != $past(phi1_o))
    ) else $error("bus_timing: 2M strobe without a phi1 edge");

endmodule

// ==== signal_denoise.sv ====
// Bus clock input conditioner
// Synchronizes one asynchronous input and rejects single-cycle glitches.
// The output level moves only after two agreeing samples, and rise and
// fall pulses mark the cycle in which the level changes.

module signal_denoise
    import a2bus_pkg::*;
(
    input  logic clk_logic_w,
    input  logic reset_i,
    input  logic sig_i,
    output logic level_o,
    output logic rise_o,
    output logic fall_o
);

    logic [sync_stages-1:0] sync_q;
    logic                   sample_prev_q;
    logic                   level_q;
    logic                   level_prev_q;
    logic                   sample_w;

    assign sample_w = sync_q[sync_stages-1];

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            sync_q        <= '0;
            sample_prev_q <= 1'b0;
            level_q       <= 1'b0;
            level_prev_q  <= 1'b0;
        end else begin
            sync_q        <= {sync_q[sync_stages-2:0], sig_i};
            sample_prev_q <= sample_w;
            // Two agreeing samples needed to move the level
            if (sample_w == sample_prev_q && sample_w != level_q) begin
                level_q <= sample_w;
            end
            level_prev_q <= level_q;
        end
    end

    assign level_o = level_q;
    assign rise_o  = level_q & ~level_prev_q;
    assign fall_o  = ~level_q & level_prev_q;

    a_no_double_edge: assert property (
        @(posedge clk_logic_w) disable iff (reset_i)
        !(rise_o && fall_o)
    ) else $error("signal_denoise: rise and fall pulses together");

endmodule

// ==== a2status_pkg.sv ====
// Status LED definitions
// One 5-bit LED word read either as the Apple video mode view
// or as the VDP state view

package a2status_pkg;

    localparam int led_w   = 5;
    localparam int gmode_w = 4;

    // Mode flags, LEDs are lit low
    typedef struct packed {
        logic text_n;
        logic shrg_n;
        logic hires_n;
        logic ramwrt_n;
        logic store80_n;
    } led_mode_view_t;

    // VDP unlock state and graphics mode, both inverted
    typedef struct packed {
        logic               unlocked_n;
        logic [gmode_w-1:0] gmode_n;
    } led_vdp_view_t;

    typedef union packed {
        logic [led_w-1:0] bits;
        led_mode_view_t   mode;
        led_vdp_view_t    vdp;
    } led_word_t;

endpackage

// ==== a2bus_pkg.sv ====
// Apple II bus definitions
// Bus byte type, card source order and DIP switch positions
// Also holds the depth of the bus clock synchronizers

package a2bus_pkg;

    // Apple data bus
    localparam int bus_data_w = 8;

    typedef logic [bus_data_w-1:0] bus_byte_t;

    // Card sources, lowest index wins the bus
    typedef enum logic [2:0] {
        src_serial       = 3'd0,
        src_sprite       = 3'd1,
        src_mockingboard = 3'd2,
        src_disk         = 3'd3,
        src_cardrom      = 3'd4
    } card_src_e;

    localparam int num_cards = 5;

    // Interrupt order is mockingboard, vdp, serial
    localparam int num_irq = 3;

    // Scanline switch, active low
    localparam int dip_scanlines_bit = 0;

    // Synchronizer flops ahead of the noise filter
    localparam int sync_stages = 2;

    localparam int rgb_w = 8;

endpackage
